// File: verilog/rtc_config.svh
`ifndef RTC_CONFIG_SVH
`define RTC_CONFIG_SVH

// Entries per queue, used by both the command and the readback queue
`define RTC_FIFO_DEPTH 8

// Clock cycles spent in each of the four bus phases
`define RTC_PHASE_CYCLES 4

// Cycles between the starts of two calendar refreshes
`define RTC_REFRESH_CYCLES 400

`define RTC_INIT_CONTROL 8'h10  // Control byte written once after reset
`define RTC_CONTROL_ADDR 8'h00  // Chip control register

`endif

// File: verilog/rtcBusPkg.sv
package rtcBusPkg;

    // Direction of one chip access
    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } rtcOp;

    // One queued chip access, 17 bits
    typedef struct packed {
        rtcOp       op;
        logic [7:0] address;
        logic [7:0] writeData;  // Ignored for reads
    } rtcCommand;

    // Result of a completed read, 16 bits
    typedef struct packed {
        logic [7:0] address;
        logic [7:0] data;
    } rtcReadback;

endpackage

// File: verilog/clockPkg.sv
package clockPkg;

    // Two BCD digits in one byte
    typedef logic [7:0] bcdByte;

    // Full calendar, seconds in the top byte
    typedef struct packed {
        bcdByte seconds;
        bcdByte minutes;
        bcdByte hours;
        bcdByte day;
        bcdByte date;
        bcdByte month;
        bcdByte year;
    } calendar;

    // Chip register map, consecutive in field order
    typedef enum logic [7:0] {
        regSeconds = 8'h21,
        regMinutes = 8'h22,
        regHours   = 8'h23,
        regDay     = 8'h24,
        regDate    = 8'h25,
        regMonth   = 8'h26,
        regYear    = 8'h27
    } calendarReg;

endpackage

// File: verilog/transactionFifo.sv
`timescale 1ns/1ps

module transactionFifo #(
    parameter type entryType = logic [7:0],
    parameter int  depth     = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  entryType pushData,
    input  logic     pop,
    output entryType popData,
    output logic     empty,
    output logic     full
);
    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptrWidth-1:0] lastSlot = ptrWidth'(depth - 1);

    entryType            storage [depth];
    logic [ptrWidth-1:0] writePtr;
    logic [ptrWidth-1:0] readPtr;
    logic [ptrWidth:0]   count;
    logic                doPush;
    logic                doPop;

    assign doPush  = push && !full;   // Push on a full queue is dropped
    assign doPop   = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == (ptrWidth + 1)'(depth));
    assign popData = storage[readPtr]; // Head entry, valid while not empty

    always_ff @(posedge clk)
    begin
        if (doPush)
            storage[writePtr] <= pushData;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            writePtr <= '0;
            readPtr  <= '0;
            count    <= '0;
        end
        else
        begin
            if (doPush)
                writePtr <= (writePtr == lastSlot) ? '0 : writePtr + 1'b1;
            if (doPop)
                readPtr <= (readPtr == lastSlot) ? '0 : readPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

// File: verilog/rtcSequencer.sv
`timescale 1ns/1ps
`include "rtc_config.svh"

module rtcSequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  clockPkg::calendar    setTime,
    input  logic                 setStrobe,
    input  logic                 queueFull,
    output logic                 push,
    output rtcBusPkg::rtcCommand command,
    output logic                 busy
);
    localparam int refreshWidth = $clog2(`RTC_REFRESH_CYCLES);
    localparam logic [refreshWidth-1:0] refreshLast = refreshWidth'(`RTC_REFRESH_CYCLES - 1);

    logic                    initPending;   // Control write not yet queued
    logic                    blockActive;   // Set or refresh block being queued
    logic                    blockIsWrite;
    logic [2:0]              stepIndex;
    clockPkg::calendar       blockTime;
    logic                    pendingSet;
    clockPkg::calendar       pendingTime;
    logic [refreshWidth-1:0] refreshCount;
    logic                    refreshDue;
    logic                    enqueueing;
    logic                    lastStep;
    logic                    startSet;
    logic                    startRefresh;
    logic                    refreshWrap;
    clockPkg::bcdByte        stepByte;
    logic [7:0]              stepAddress;

    assign enqueueing   = initPending || blockActive;
    assign push         = enqueueing && !queueFull;   // Hold the entry while full
    assign lastStep     = (stepIndex == 3'd6);
    assign busy         = blockActive || pendingSet;
    assign refreshWrap  = (refreshCount == refreshLast);

    // New blocks only start between blocks, a set before a refresh
    assign startSet     = !enqueueing && (setStrobe || pendingSet);
    assign startRefresh = !enqueueing && !startSet && refreshDue;

    // Register addresses follow the field order
    assign stepAddress  = 8'(clockPkg::regSeconds) + {5'd0, stepIndex};

    always_comb
    begin
        case (stepIndex)
            3'd0:    stepByte = blockTime.seconds;
            3'd1:    stepByte = blockTime.minutes;
            3'd2:    stepByte = blockTime.hours;
            3'd3:    stepByte = blockTime.day;
            3'd4:    stepByte = blockTime.date;
            3'd5:    stepByte = blockTime.month;
            default: stepByte = blockTime.year;
        endcase
    end

    always_comb
    begin
        if (initPending)
        begin
            command.op        = rtcBusPkg::opWrite;
            command.address   = `RTC_CONTROL_ADDR;
            command.writeData = `RTC_INIT_CONTROL;
        end
        else
        begin
            command.op        = blockIsWrite ? rtcBusPkg::opWrite : rtcBusPkg::opRead;
            command.address   = stepAddress;
            command.writeData = blockIsWrite ? stepByte : 8'h00;
        end
    end

    // Refresh timer, the due flag waits for a free slot
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            refreshCount <= '0;
            refreshDue   <= 1'b0;
        end
        else
        begin
            refreshCount <= refreshWrap ? '0 : refreshCount + 1'b1;
            refreshDue   <= (refreshDue && !startRefresh) || refreshWrap;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            initPending  <= 1'b1;
            blockActive  <= 1'b0;
            blockIsWrite <= 1'b0;
            stepIndex    <= 3'd0;
            pendingSet   <= 1'b0;
        end
        else
        begin
            if (push && initPending)
                initPending <= 1'b0;
            if (push && blockActive)
            begin
                stepIndex <= lastStep ? 3'd0 : stepIndex + 1'b1;
                if (lastStep)
                    blockActive <= 1'b0;
            end
            if (startSet)
            begin
                blockActive  <= 1'b1;
                blockIsWrite <= 1'b1;
                stepIndex    <= 3'd0;
                pendingSet   <= 1'b0;  // A fresh strobe supersedes the pending set
            end
            else if (startRefresh)
            begin
                blockActive  <= 1'b1;
                blockIsWrite <= 1'b0;
                stepIndex    <= 3'd0;
            end
            if (enqueueing && setStrobe)
                pendingSet <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (startSet)
            blockTime <= setStrobe ? setTime : pendingTime;
        if (enqueueing && setStrobe)
            pendingTime <= setTime;  // Later sets overwrite
    end

endmodule

// File: verilog/rtcBusEngine.sv
`timescale 1ns/1ps
`include "rtc_config.svh"

module rtcBusEngine (
    input  logic                  clk,
    input  logic                  reset,
    input  rtcBusPkg::rtcCommand  command,
    input  logic                  queueEmpty,
    output logic                  pop,
    input  logic                  readbackFull,
    output logic                  readbackPush,
    output rtcBusPkg::rtcReadback readback,
    output logic                  chipSelect,
    output logic                  readStrobe,
    output logic                  writeStrobe,
    output logic                  addressOrData,
    inout  wire  [7:0]            dataAddress
);
    localparam int cycleWidth = (`RTC_PHASE_CYCLES > 2) ? $clog2(`RTC_PHASE_CYCLES) : 1;
    localparam logic [cycleWidth-1:0] phaseLast   = cycleWidth'(`RTC_PHASE_CYCLES - 1);
    // The idle cycle that pops the next entry is the last cycle of the closing gap
    localparam logic [cycleWidth-1:0] releaseLast = cycleWidth'(`RTC_PHASE_CYCLES - 2);

    typedef enum logic [2:0] {
        phaseIdle,
        phaseAddress,
        phaseGap,
        phaseData,
        phaseRelease
    } phaseState;

    phaseState             state;
    logic [cycleWidth-1:0] cycleCount;
    rtcBusPkg::rtcCommand  current;
    logic                  isRead;
    logic                  phaseDone;
    logic                  sampleNow;
    logic                  driveBus;
    logic [7:0]            busOut;

    assign isRead    = (current.op == rtcBusPkg::opRead);
    assign phaseDone = (cycleCount == phaseLast);
    assign sampleNow = (state == phaseData) && phaseDone && isRead;

    // Reads wait for room in the readback queue
    assign pop = (state == phaseIdle) && !queueEmpty &&
                 ((command.op == rtcBusPkg::opWrite) || !readbackFull);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= phaseIdle;
            cycleCount   <= '0;
            readbackPush <= 1'b0;
        end
        else
        begin
            readbackPush <= sampleNow;  // One cycle after the sample
            case (state)
                phaseIdle:
                    if (pop)
                    begin
                        state      <= phaseAddress;
                        cycleCount <= '0;
                    end
                phaseAddress:
                begin
                    cycleCount <= phaseDone ? '0 : cycleCount + 1'b1;
                    if (phaseDone)
                        state <= phaseGap;
                end
                phaseGap:
                begin
                    cycleCount <= phaseDone ? '0 : cycleCount + 1'b1;
                    if (phaseDone)
                        state <= phaseData;
                end
                phaseData:
                begin
                    cycleCount <= phaseDone ? '0 : cycleCount + 1'b1;
                    if (phaseDone)
                        state <= phaseRelease;
                end
                phaseRelease:
                begin
                    cycleCount <= (cycleCount == releaseLast) ? '0 : cycleCount + 1'b1;
                    if (cycleCount == releaseLast)
                        state <= phaseIdle;
                end
                default:
                    state <= phaseIdle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            current <= command;
        if (sampleNow)
        begin
            readback.address <= current.address;
            readback.data    <= dataAddress;
        end
    end

    // Chip select spans address, gap and data phases
    assign chipSelect    = !((state == phaseAddress) || (state == phaseGap) ||
                             (state == phaseData));
    assign writeStrobe   = !((state == phaseAddress) || ((state == phaseData) && !isRead));
    assign readStrobe    = !((state == phaseData) && isRead);
    assign addressOrData = (state == phaseData);

    assign driveBus    = (state == phaseAddress) || ((state == phaseData) && !isRead);
    assign busOut      = (state == phaseAddress) ? current.address : current.writeData;
    assign dataAddress = driveBus ? busOut : 8'bz;  // Released while the chip drives

endmodule

// File: verilog/calendarAssembler.sv
`timescale 1ns/1ps

module calendarAssembler (
    input  logic                  clk,
    input  logic                  reset,
    input  rtcBusPkg::rtcReadback readback,
    input  logic                  empty,
    output logic                  pop,
    output clockPkg::calendar     calendarOut,
    output logic                  calendarValid
);
    clockPkg::calendar staging;
    logic [2:0]        fieldCount;  // Bytes seen since the last seconds byte
    logic              snapshotDone;

    assign pop = !empty;
    assign snapshotDone = pop && (readback.address == 8'(clockPkg::regYear)) &&
                          (fieldCount == 3'd6);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fieldCount    <= 3'd0;
            calendarValid <= 1'b0;
        end
        else
        begin
            calendarValid <= snapshotDone;
            if (pop)
                fieldCount <= (readback.address == 8'(clockPkg::regSeconds)) ? 3'd1
                              : fieldCount + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            case (readback.address)
                8'(clockPkg::regSeconds): staging.seconds <= readback.data;
                8'(clockPkg::regMinutes): staging.minutes <= readback.data;
                8'(clockPkg::regHours):   staging.hours   <= readback.data;
                8'(clockPkg::regDay):     staging.day     <= readback.data;
                8'(clockPkg::regDate):    staging.date    <= readback.data;
                8'(clockPkg::regMonth):   staging.month   <= readback.data;
                8'(clockPkg::regYear):    staging.year    <= readback.data;
                default:                  staging         <= staging;
            endcase
        end
        if (snapshotDone)
            calendarOut <= {staging[55:8], readback.data};  // Year arrives this cycle
    end

endmodule

// File: verilog/rtcClockTop.sv
`timescale 1ns/1ps
`include "rtc_config.svh"

module rtcClockTop (
    input  logic              clk,
    input  logic              reset,
    input  clockPkg::calendar setTime,
    input  logic              setStrobe,
    output logic              busy,
    output clockPkg::calendar calendarOut,
    output logic              calendarValid,
    output logic              chipSelect,
    output logic              readStrobe,
    output logic              writeStrobe,
    output logic              addressOrData,
    inout  wire  [7:0]        dataAddress
);
    rtcBusPkg::rtcCommand  seqCommand;
    rtcBusPkg::rtcCommand  headCommand;
    rtcBusPkg::rtcReadback engineReadback;
    rtcBusPkg::rtcReadback headReadback;
    logic                  seqPush;
    logic                  commandFull;
    logic                  commandEmpty;
    logic                  commandPop;
    logic                  readbackPush;
    logic                  readbackFull;
    logic                  readbackEmpty;
    logic                  readbackPop;

    rtcSequencer sequencer_i (
        .clk       (clk),
        .reset     (reset),
        .setTime   (setTime),
        .setStrobe (setStrobe),
        .queueFull (commandFull),
        .push      (seqPush),
        .command   (seqCommand),
        .busy      (busy)
    );

    transactionFifo #(
        .entryType (rtcBusPkg::rtcCommand),
        .depth     (`RTC_FIFO_DEPTH)
    ) commandQueue (
        .clk      (clk),
        .reset    (reset),
        .push     (seqPush),
        .pushData (seqCommand),
        .pop      (commandPop),
        .popData  (headCommand),
        .empty    (commandEmpty),
        .full     (commandFull)
    );

    rtcBusEngine busEngine_i (
        .clk           (clk),
        .reset         (reset),
        .command       (headCommand),
        .queueEmpty    (commandEmpty),
        .pop           (commandPop),
        .readbackFull  (readbackFull),
        .readbackPush  (readbackPush),
        .readback      (engineReadback),
        .chipSelect    (chipSelect),
        .readStrobe    (readStrobe),
        .writeStrobe   (writeStrobe),
        .addressOrData (addressOrData),
        .dataAddress   (dataAddress)
    );

    transactionFifo #(
        .entryType (rtcBusPkg::rtcReadback),
        .depth     (`RTC_FIFO_DEPTH)
    ) readbackQueue (
        .clk      (clk),
        .reset    (reset),
        .push     (readbackPush),
        .pushData (engineReadback),
        .pop      (readbackPop),
        .popData  (headReadback),
        .empty    (readbackEmpty),
        .full     (readbackFull)
    );

    calendarAssembler assembler_i (
        .clk           (clk),
        .reset         (reset),
        .readback      (headReadback),
        .empty         (readbackEmpty),
        .pop           (readbackPop),
        .calendarOut   (calendarOut),
        .calendarValid (calendarValid)
    );

endmodule

// File: testbench/rtcChipModel.sv
`timescale 1ns/1ps

module rtcChipModel (
    input  logic              clk,
    input  logic              reset,
    input  logic              chipSelect,
    input  logic              readStrobe,
    input  logic              writeStrobe,
    input  logic              addressOrData,
    inout  wire  [7:0]        dataAddress,
    input  logic              pokeEnable,
    input  clockPkg::calendar pokeTime
);
    logic [7:0] registers [256];
    logic [7:0] latchedAddress;
    logic       driveRead;

    // Chip drives the bus for the whole read data phase
    assign driveRead   = !chipSelect && addressOrData && !readStrobe;
    assign dataAddress = driveRead ? registers[latchedAddress] : 8'bz;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            latchedAddress <= 8'h00;
            for (int i = 0; i < 256; i++)
                registers[i] <= 8'(i) ^ 8'hA5;  // Recognizable power-up contents
        end
        else
        begin
            if (!chipSelect && !addressOrData && !writeStrobe)
                latchedAddress <= dataAddress;
            if (!chipSelect && addressOrData && !writeStrobe)
                registers[latchedAddress] <= dataAddress;
            // Direct load of the calendar registers, bypassing the bus
            if (pokeEnable)
            begin
                registers[clockPkg::regSeconds] <= pokeTime.seconds;
                registers[clockPkg::regMinutes] <= pokeTime.minutes;
                registers[clockPkg::regHours]   <= pokeTime.hours;
                registers[clockPkg::regDay]     <= pokeTime.day;
                registers[clockPkg::regDate]    <= pokeTime.date;
                registers[clockPkg::regMonth]   <= pokeTime.month;
                registers[clockPkg::regYear]    <= pokeTime.year;
            end
        end
    end

endmodule

// File: testbench/rtcClockChecker.sv
`timescale 1ns/1ps
`include "rtc_config.svh"

module rtcClockChecker (
    input  logic              clk,
    input  logic              reset,
    input  clockPkg::calendar setTime,
    input  logic              setStrobe,
    input  logic              pokeEnable,
    input  clockPkg::calendar pokeTime,
    input  logic              chipSelect,
    input  logic              readStrobe,
    input  logic              writeStrobe,
    input  logic              addressOrData,
    input  wire  [7:0]        dataAddress,
    input  logic              busy,
    input  clockPkg::calendar calendarOut,
    input  logic              calendarValid,
    input  logic              finalCheck,
    output int                errorCount,
    output int                checkCount
);
    logic [7:0]        model [256];           // Expected chip registers
    clockPkg::calendar setHistory [$];        // Every strobed set in arrival order
    clockPkg::calendar expectedSnapshots [$];
    clockPkg::calendar readStaging;
    clockPkg::calendar writeStaging;
    clockPkg::calendar lastWritten;
    logic [7:0]        busAddress;
    logic [7:0]        busData;
    logic [7:0]        readExpected;
    logic              inTransaction;
    logic              sawRead;
    logic              firstSeen;
    logic              setSeen;               // Set strobe sampled on the previous edge
    int                readIndex;
    int                writeIndex;
    int                matchFrom;             // Older sets may have been overwritten
    int                snapshotCount;

    task automatic checkValue(input string what, input logic [63:0] actual,
                              input logic [63:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic finishTransaction();
        int found;
        int field;
        found = -1;
        field = int'(busAddress) - int'(clockPkg::regSeconds);
        if (!firstSeen)
        begin
            firstSeen = 1'b1;
            checkValue("first access is a write", !sawRead, 1);
            checkValue("first access address", busAddress, `RTC_CONTROL_ADDR);
            checkValue("first access data", busData, `RTC_INIT_CONTROL);
        end
        else if (sawRead)
        begin
            checkValue("read data", busData, readExpected);
            checkValue("writes left open before a read", writeIndex, 0);
            readIndex = (field == 0) ? 0 : readIndex + 1;
            if (field >= 0 && field < 7)
                readStaging[55 - 8*field -: 8] = readExpected;
            if (field == 6 && readIndex == 6)
                expectedSnapshots.push_back(readStaging);  // Complete refresh
        end
        else
        begin
            checkValue("set write address", busAddress, 8'(clockPkg::regSeconds) + 8'(writeIndex));
            writeStaging[55 - 8*writeIndex -: 8] = busData;
            writeIndex++;
            if (writeIndex == 7)
            begin
                writeIndex = 0;
                checkCount++;
                for (int i = matchFrom; i < setHistory.size(); i++)
                    if (found < 0 && setHistory[i] == writeStaging)
                        found = i;
                if (found < 0)
                begin
                    errorCount++;
                    $display("ERR %0t: written calendar %h matches no later set",
                             $time, writeStaging);
                end
                else
                    matchFrom = found + 1;
                lastWritten = writeStaging;
            end
        end
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 256; i++)
                model[i] = 8'(i) ^ 8'hA5;
            setHistory.delete();
            expectedSnapshots.delete();
            inTransaction = 1'b0;
            sawRead       = 1'b0;
            firstSeen     = 1'b0;
            setSeen       = 1'b0;
            readIndex     = 0;
            writeIndex    = 0;
            matchFrom     = 0;
            snapshotCount = 0;
            errorCount    = 0;
            checkCount    = 0;
        end
        else
        begin
            // A set either starts its block or waits as pending
            if (setSeen)
                checkValue("busy after a set strobe", busy, 1);
            setSeen = setStrobe;
            if (!chipSelect && !addressOrData && !writeStrobe)
            begin
                busAddress    = dataAddress;
                inTransaction = 1'b1;
                sawRead       = 1'b0;
            end
            if (!chipSelect && addressOrData && !writeStrobe)
            begin
                busData           = dataAddress;
                model[busAddress] = dataAddress;  // Same edge as the chip write
            end
            if (!chipSelect && addressOrData && !readStrobe)
            begin
                busData      = dataAddress;
                readExpected = model[busAddress];  // Last cycle is the one the DUT samples
                sawRead      = 1'b1;
            end
            if (chipSelect && inTransaction)
            begin
                inTransaction = 1'b0;
                finishTransaction();
            end
            if (pokeEnable)
                for (int k = 0; k < 7; k++)
                    model[8'h21 + k] = pokeTime[55 - 8*k -: 8];
            if (setStrobe)
                setHistory.push_back(setTime);
            if (calendarValid)
            begin
                snapshotCount++;
                if (expectedSnapshots.size() == 0)
                begin
                    errorCount++;
                    $display("calendarValid pulsed at %0t with no completed refresh on the bus",
                             $time);
                end
                else
                    checkValue("calendar snapshot", calendarOut, expectedSnapshots.pop_front());
            end
            if (finalCheck)
            begin
                if (setHistory.size() > 0)
                    checkValue("last written calendar", lastWritten, setHistory[$]);
                if (snapshotCount == 0)
                begin
                    errorCount++;
                    $display("No calendar snapshot was produced during the run");
                end
            end
        end
    end

endmodule

// File: testbench/rtcClockAssertions.sv
`timescale 1ns/1ps
`include "rtc_config.svh"

module rtcClockAssertions (
    input logic clk,
    input logic reset,
    input logic chipSelect,
    input logic readStrobe,
    input logic writeStrobe,
    input logic addressOrData,
    input logic driveBus
);
    int failCount = 0;

    strobesExclusive: assert property (@(posedge clk) disable iff (reset)
        readStrobe || writeStrobe)
    else
    begin
        failCount++;
        $error("Read and write strobes low together");
    end

    // Address, gap and data phases, then chip select released
    fourPhases: assert property (@(posedge clk) disable iff (reset)
        $fell(chipSelect) |->
            (!chipSelect && !addressOrData && !writeStrobe && readStrobe)[*`RTC_PHASE_CYCLES]
            ##1 (!chipSelect && !addressOrData && writeStrobe && readStrobe)[*`RTC_PHASE_CYCLES]
            ##1 (!chipSelect && addressOrData && (readStrobe != writeStrobe))[*`RTC_PHASE_CYCLES]
            ##1 chipSelect)
    else
    begin
        failCount++;
        $error("Bus access broke the four-phase order");
    end

    busReleasedOnRead: assert property (@(posedge clk) disable iff (reset)
        !readStrobe |-> !driveBus)
    else
    begin
        failCount++;
        $error("DUT drives the bus during a read phase");
    end

    idleAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> chipSelect && readStrobe && writeStrobe && !addressOrData && !driveBus)
    else
    begin
        failCount++;
        $error("Bus not idle after reset");
    end

endmodule

// File: testbench/rtcClockTb.sv
`timescale 1ns/1ps

module rtcClockTb;
    logic              clk;
    logic              reset;
    clockPkg::calendar setTime;
    logic              setStrobe;
    logic              pokeEnable;
    clockPkg::calendar pokeTime;
    logic              finalCheck;
    logic              busy;
    clockPkg::calendar calendarOut;
    logic              calendarValid;
    logic              chipSelect;
    logic              readStrobe;
    logic              writeStrobe;
    logic              addressOrData;
    wire  [7:0]        dataAddress;
    logic [31:0]       rngState;
    logic              timedOut;
    int                errorCount;
    int                checkCount;
    int                assertionFails;

    rtcClockTop dut_i (
        .clk           (clk),
        .reset         (reset),
        .setTime       (setTime),
        .setStrobe     (setStrobe),
        .busy          (busy),
        .calendarOut   (calendarOut),
        .calendarValid (calendarValid),
        .chipSelect    (chipSelect),
        .readStrobe    (readStrobe),
        .writeStrobe   (writeStrobe),
        .addressOrData (addressOrData),
        .dataAddress   (dataAddress)
    );

    rtcChipModel chip_i (
        .clk           (clk),
        .reset         (reset),
        .chipSelect    (chipSelect),
        .readStrobe    (readStrobe),
        .writeStrobe   (writeStrobe),
        .addressOrData (addressOrData),
        .dataAddress   (dataAddress),
        .pokeEnable    (pokeEnable),
        .pokeTime      (pokeTime)
    );

    rtcClockChecker checker_i (
        .clk           (clk),
        .reset         (reset),
        .setTime       (setTime),
        .setStrobe     (setStrobe),
        .pokeEnable    (pokeEnable),
        .pokeTime      (pokeTime),
        .chipSelect    (chipSelect),
        .readStrobe    (readStrobe),
        .writeStrobe   (writeStrobe),
        .addressOrData (addressOrData),
        .dataAddress   (dataAddress),
        .busy          (busy),
        .calendarOut   (calendarOut),
        .calendarValid (calendarValid),
        .finalCheck    (finalCheck),
        .errorCount    (errorCount),
        .checkCount    (checkCount)
    );

    bind rtcBusEngine rtcClockAssertions assertions_i (
        .clk           (clk),
        .reset         (reset),
        .chipSelect    (chipSelect),
        .readStrobe    (readStrobe),
        .writeStrobe   (writeStrobe),
        .addressOrData (addressOrData),
        .driveBus      (driveBus)
    );

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // Random value from low to low+span-1 in two BCD digits
    function automatic logic [7:0] randomBcd(input int low, input int span);
        int value;
        value = low + int'(nextRandom() % span);
        return 8'((value / 10) * 16 + value % 10);
    endfunction

    function automatic clockPkg::calendar randomCalendar();
        clockPkg::calendar c;
        c.seconds = randomBcd(0, 60);
        c.minutes = randomBcd(0, 60);
        c.hours   = randomBcd(0, 24);
        c.day     = randomBcd(1, 7);
        c.date    = randomBcd(1, 28);
        c.month   = randomBcd(1, 12);
        c.year    = randomBcd(0, 100);
        return c;
    endfunction

    task automatic runStimulus(input int cycles);
        logic [31:0] r;
        for (int n = 0; n < cycles; n++)
        begin
            @(posedge clk);
            r = nextRandom();
            if (n >= cycles / 2 && n < cycles / 2 + 40)
                setStrobe <= (r[1:0] == 2'b00);  // Dense burst fills the command queue
            else
                setStrobe <= (r[7:0] < 8'd2);
            setTime    <= randomCalendar();
            pokeEnable <= (r[16:8] == 9'd0);
            pokeTime   <= randomCalendar();
        end
        @(posedge clk);
        setStrobe  <= 1'b0;
        pokeEnable <= 1'b0;
    endtask

    task automatic waitForSnapshot(input int limit, output logic failed);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!calendarValid && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        failed = !calendarValid;
        if (failed)
            $display("Timeout: no calendar snapshot appeared within %0d cycles", limit);
    endtask

    task automatic waitForBusyLow(input int limit, output logic failed);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        failed = busy;
        if (failed)
            $display("Timeout: busy stayed high for %0d cycles after the last set", limit);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        rngState   = 32'h19c;
        reset      = 1'b1;
        setTime    = '0;
        setStrobe  = 1'b0;
        pokeEnable = 1'b0;
        pokeTime   = '0;
        finalCheck = 1'b0;
        timedOut   = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        waitForSnapshot(2000, timedOut);  // Init write and first refresh
        if (!timedOut)
        begin
            runStimulus(6000);
            repeat (2) @(posedge clk);
            waitForBusyLow(3000, timedOut);
        end
        // Second snapshot is read after the last set has reached the chip
        if (!timedOut)
            waitForSnapshot(2000, timedOut);
        if (!timedOut)
            waitForSnapshot(2000, timedOut);
        @(posedge clk);
        finalCheck <= 1'b1;
        @(posedge clk);
        finalCheck <= 1'b0;
        @(negedge clk);
        assertionFails = dut_i.busEngine_i.assertions_i.failCount;
        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 checkCount, errorCount, assertionFails, timedOut);
        if (errorCount == 0 && assertionFails == 0 && !timedOut)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: rtcClock.f
+incdir+verilog
verilog/rtcBusPkg.sv
verilog/clockPkg.sv
verilog/transactionFifo.sv
verilog/rtcSequencer.sv
verilog/rtcBusEngine.sv
verilog/calendarAssembler.sv
verilog/rtcClockTop.sv
testbench/rtcChipModel.sv
testbench/rtcClockChecker.sv
testbench/rtcClockAssertions.sv
testbench/rtcClockTb.sv
